//--- common/rv_ex_defines.svh
`ifndef RV_EX_DEFINES_SVH
`define RV_EX_DEFINES_SVH

// Data and address width.
`define RV_XLEN 32

// Architectural registers.
`define RV_NREGS 32

// Register index width.
`define RV_REG_W 5

`endif

//--- common/rv_ex_pkg.sv
`default_nettype none

package rv_ex_pkg;

  // Major opcodes of the supported RV32I instructions.
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } opcode_t;

  // Low three bits follow funct3, bit 3 follows funct7[5].
  typedef enum logic [3:0] {
    alu_add   = 4'b0000,
    alu_sub   = 4'b1000,
    alu_sll   = 4'b0001,
    alu_slt   = 4'b0010,
    alu_sltu  = 4'b0011,
    alu_xor   = 4'b0100,
    alu_srl   = 4'b0101,
    alu_sra   = 4'b1101,
    alu_or    = 4'b0110,
    alu_and   = 4'b0111,
    alu_passb = 4'b1111
  } alu_op_t;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } cmp_op_t;

  typedef enum logic [2:0] {
    sb = 3'b000,
    sh = 3'b001,
    sw = 3'b010
  } store_w_t;

endpackage

`default_nettype wire

//--- compile.f
+incdir+common
+incdir+verification
common/rv_ex_pkg.sv
execute/rv_alu.sv
execute/rv_branch_cmp.sv
execute/rv_execute.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_result.sv
rtl/rv_ex_top.sv
verification/rv_ex_tb.sv

//--- execute/rv_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_alu (
  input  wire rv_ex_pkg::alu_op_t op_i,
  input  wire  [`RV_XLEN-1:0]     a_i,
  input  wire  [`RV_XLEN-1:0]     b_i,
  output logic [`RV_XLEN-1:0]     f_o
);

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      rv_ex_pkg::alu_add:   f_o = a_i + b_i;
      rv_ex_pkg::alu_sub:   f_o = a_i - b_i;
      rv_ex_pkg::alu_sll:   f_o = a_i << shamt;
      rv_ex_pkg::alu_slt:   f_o = `RV_XLEN'($signed(a_i) < $signed(b_i));
      rv_ex_pkg::alu_sltu:  f_o = `RV_XLEN'(a_i < b_i);
      rv_ex_pkg::alu_xor:   f_o = a_i ^ b_i;
      rv_ex_pkg::alu_srl:   f_o = a_i >> shamt;
      rv_ex_pkg::alu_sra:   f_o = $unsigned($signed(a_i) >>> shamt);
      rv_ex_pkg::alu_or:    f_o = a_i | b_i;
      rv_ex_pkg::alu_and:   f_o = a_i & b_i;
      rv_ex_pkg::alu_passb: f_o = b_i;
      default:              f_o = a_i + b_i;
    endcase
  end

endmodule

`default_nettype wire

//--- execute/rv_branch_cmp.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_branch_cmp (
  input  wire rv_ex_pkg::cmp_op_t op_i,
  input  wire  [`RV_XLEN-1:0]     a_i,
  input  wire  [`RV_XLEN-1:0]     b_i,
  output logic                    taken_o
);

  logic eq, lt_s, lt_u;

  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    case (op_i)
      rv_ex_pkg::beq:  taken_o = eq;
      rv_ex_pkg::bne:  taken_o = !eq;
      rv_ex_pkg::blt:  taken_o = lt_s;
      rv_ex_pkg::bge:  taken_o = !lt_s;
      rv_ex_pkg::bltu: taken_o = lt_u;
      rv_ex_pkg::bgeu: taken_o = !lt_u;
      default:         taken_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- execute/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_execute (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       stall_i,
  input  wire                       ex_valid_i,
  input  wire  [`RV_XLEN-1:0]       ex_pc_i,
  input  wire rv_ex_pkg::opcode_t   ex_opcode_i,
  input  wire rv_ex_pkg::alu_op_t   ex_alu_op_i,
  input  wire rv_ex_pkg::cmp_op_t   ex_cmp_op_i,
  input  wire rv_ex_pkg::store_w_t  ex_store_w_i,
  input  wire  [`RV_REG_W-1:0]      ex_rs1_idx_i,
  input  wire  [`RV_REG_W-1:0]      ex_rs2_idx_i,
  input  wire  [`RV_REG_W-1:0]      ex_rd_i,
  input  wire                       ex_reg_write_i,
  input  wire  [`RV_XLEN-1:0]       ex_rs1_val_i,
  input  wire  [`RV_XLEN-1:0]       ex_rs2_val_i,
  input  wire  [`RV_XLEN-1:0]       ex_imm_i,
  input  wire                       ex_a_sel_pc_i,
  input  wire                       ex_b_sel_imm_i,
  input  wire                       wb_we_i,
  input  wire  [`RV_REG_W-1:0]      wb_rd_i,
  input  wire  [`RV_XLEN-1:0]       wb_data_i,
  output logic                      mem_valid_o,
  output logic [`RV_REG_W-1:0]      mem_rd_o,
  output logic                      mem_reg_write_o,
  output logic [`RV_XLEN-1:0]       mem_alu_o,
  output logic                      mem_link_o,
  output logic [`RV_XLEN-1:0]       mem_pc4_o,
  output logic                      mem_store_o,
  output logic [3:0]                mem_be_o,
  output logic [`RV_XLEN-1:0]       mem_sdata_o,
  output logic                      mem_br_taken_o,
  output logic [`RV_XLEN-1:0]       mem_target_o
);

  logic [`RV_XLEN-1:0] rs1_fwd, rs2_fwd, alu_a, alu_b, alu_f, target;
  logic                cmp_taken, is_jump, br_taken;
  logic [3:0]          be_mask;

  // Youngest producer wins: execute register first, then writeback.
  function automatic logic [`RV_XLEN-1:0] fwd(input logic [`RV_REG_W-1:0] idx,
                                              input logic [`RV_XLEN-1:0] dec_val);
    if (mem_reg_write_o && mem_rd_o == idx && idx != '0) begin
      return mem_link_o ? mem_pc4_o : mem_alu_o;
    end
    if (wb_we_i && wb_rd_i == idx && idx != '0) return wb_data_i;
    return dec_val;
  endfunction

  always_comb begin
    rs1_fwd = fwd(ex_rs1_idx_i, ex_rs1_val_i);
    rs2_fwd = fwd(ex_rs2_idx_i, ex_rs2_val_i);
  end

  assign alu_a = ex_a_sel_pc_i ? ex_pc_i : rs1_fwd;
  assign alu_b = ex_b_sel_imm_i ? ex_imm_i : rs2_fwd;

  rv_alu alu (
    .op_i (ex_alu_op_i),
    .a_i  (alu_a),
    .b_i  (alu_b),
    .f_o  (alu_f)
  );

  rv_branch_cmp cmp (
    .op_i    (ex_cmp_op_i),
    .a_i     (rs1_fwd),
    .b_i     (rs2_fwd),
    .taken_o (cmp_taken)
  );

  assign is_jump  = (ex_opcode_i == rv_ex_pkg::op_jal) || (ex_opcode_i == rv_ex_pkg::op_jalr);
  assign br_taken = is_jump || (ex_opcode_i == rv_ex_pkg::op_br && cmp_taken);
  assign target   = (ex_opcode_i == rv_ex_pkg::op_jalr) ? {alu_f[`RV_XLEN-1:1], 1'b0} : alu_f;

  always_comb begin
    case (ex_store_w_i)
      rv_ex_pkg::sb: be_mask = 4'b0001;
      rv_ex_pkg::sh: be_mask = 4'b0011;
      default:       be_mask = 4'b1111;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid_o     <= 1'b0;
      mem_reg_write_o <= 1'b0;
      mem_store_o     <= 1'b0;
      mem_br_taken_o  <= 1'b0;
    end else if (!stall_i) begin
      mem_valid_o     <= ex_valid_i;
      mem_reg_write_o <= ex_valid_i & ex_reg_write_i;
      mem_store_o     <= ex_valid_i & (ex_opcode_i == rv_ex_pkg::op_store);
      mem_br_taken_o  <= ex_valid_i & br_taken;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      mem_rd_o     <= ex_rd_i;
      mem_alu_o    <= alu_f;
      mem_link_o   <= is_jump;
      mem_pc4_o    <= ex_pc_i + `RV_XLEN'(4);
      mem_be_o     <= be_mask << alu_f[1:0];
      mem_sdata_o  <= rs2_fwd;
      mem_target_o <= target;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_decode (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      instr_valid_i,
  input  wire  [31:0]              instr_i,
  input  wire  [`RV_XLEN-1:0]      pc_i,
  input  wire                      stall_i,
  output logic [`RV_REG_W-1:0]     rs1_idx_o,
  output logic [`RV_REG_W-1:0]     rs2_idx_o,
  input  wire  [`RV_XLEN-1:0]      rs1_val_i,
  input  wire  [`RV_XLEN-1:0]      rs2_val_i,
  output logic                     ex_valid_o,
  output logic [`RV_XLEN-1:0]      ex_pc_o,
  output rv_ex_pkg::opcode_t       ex_opcode_o,
  output rv_ex_pkg::alu_op_t       ex_alu_op_o,
  output rv_ex_pkg::cmp_op_t       ex_cmp_op_o,
  output rv_ex_pkg::store_w_t      ex_store_w_o,
  output logic [`RV_REG_W-1:0]     ex_rs1_idx_o,
  output logic [`RV_REG_W-1:0]     ex_rs2_idx_o,
  output logic [`RV_REG_W-1:0]     ex_rd_o,
  output logic                     ex_reg_write_o,
  output logic [`RV_XLEN-1:0]      ex_rs1_val_o,
  output logic [`RV_XLEN-1:0]      ex_rs2_val_o,
  output logic [`RV_XLEN-1:0]      ex_imm_o,
  output logic                     ex_a_sel_pc_o,
  output logic                     ex_b_sel_imm_o
);

  rv_ex_pkg::opcode_t  opcode;
  rv_ex_pkg::alu_op_t  alu_op;
  logic [2:0]          funct3;
  logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j, imm;
  logic                a_sel_pc, b_sel_imm, reg_write;

  assign opcode    = rv_ex_pkg::opcode_t'(instr_i[6:0]);
  assign funct3    = instr_i[14:12];
  assign rs1_idx_o = instr_i[19:15];
  assign rs2_idx_o = instr_i[24:20];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    alu_op    = rv_ex_pkg::alu_add;
    imm       = imm_i;
    a_sel_pc  = 1'b0;
    b_sel_imm = 1'b1;
    reg_write = 1'b0;
    case (opcode)
      rv_ex_pkg::op_lui: begin
        alu_op    = rv_ex_pkg::alu_passb;
        imm       = imm_u;
        reg_write = 1'b1;
      end
      rv_ex_pkg::op_auipc: begin
        a_sel_pc  = 1'b1;
        imm       = imm_u;
        reg_write = 1'b1;
      end
      rv_ex_pkg::op_jal: begin
        a_sel_pc  = 1'b1;
        imm       = imm_j;
        reg_write = 1'b1;
      end
      rv_ex_pkg::op_jalr: reg_write = 1'b1;
      // Branch target is pc + imm through the ALU.
      rv_ex_pkg::op_br: begin
        a_sel_pc = 1'b1;
        imm      = imm_b;
      end
      rv_ex_pkg::op_store: imm = imm_s;
      rv_ex_pkg::op_imm, rv_ex_pkg::op_reg: begin
        alu_op = rv_ex_pkg::alu_op_t'({1'b0, funct3});
        // funct7[5] picks SRA, and SUB for the register form only.
        if (funct3 == 3'b101 || (opcode == rv_ex_pkg::op_reg && funct3 == 3'b000)) begin
          alu_op = rv_ex_pkg::alu_op_t'({instr_i[30], funct3});
        end
        b_sel_imm = (opcode == rv_ex_pkg::op_imm);
        reg_write = 1'b1;
      end
      default: reg_write = 1'b0;
    endcase
    if (instr_i[11:7] == '0) begin
      reg_write = 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid_o     <= 1'b0;
      ex_reg_write_o <= 1'b0;
    end else if (!stall_i) begin
      ex_valid_o     <= instr_valid_i;
      ex_reg_write_o <= instr_valid_i & reg_write;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall_i) begin
      ex_pc_o        <= pc_i;
      ex_opcode_o    <= opcode;
      ex_alu_op_o    <= alu_op;
      ex_cmp_op_o    <= rv_ex_pkg::cmp_op_t'(funct3);
      ex_store_w_o   <= rv_ex_pkg::store_w_t'(funct3);
      ex_rs1_idx_o   <= rs1_idx_o;
      ex_rs2_idx_o   <= rs2_idx_o;
      ex_rd_o        <= instr_i[11:7];
      ex_rs1_val_o   <= rs1_val_i;
      ex_rs2_val_o   <= rs2_val_i;
      ex_imm_o       <= imm;
      ex_a_sel_pc_o  <= a_sel_pc;
      ex_b_sel_imm_o <= b_sel_imm;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_ex_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_ex_top (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  instr_valid_i,
  input  wire  [31:0]          instr_i,
  input  wire  [`RV_XLEN-1:0]  pc_i,
  input  wire                  stall_i,
  output logic                 wb_valid_o,
  output logic                 wb_we_o,
  output logic [`RV_REG_W-1:0] wb_rd_o,
  output logic [`RV_XLEN-1:0]  wb_data_o,
  output logic                 st_valid_o,
  output logic [`RV_XLEN-1:0]  st_addr_o,
  output logic [3:0]           st_be_o,
  output logic [`RV_XLEN-1:0]  st_data_o,
  output logic                 br_taken_o,
  output logic [`RV_XLEN-1:0]  br_target_o
);

  logic [`RV_REG_W-1:0] rs1_idx, rs2_idx;
  logic [`RV_XLEN-1:0]  rs1_val, rs2_val;

  logic                 ex_valid, ex_reg_write, ex_a_sel_pc, ex_b_sel_imm;
  logic [`RV_XLEN-1:0]  ex_pc, ex_rs1_val, ex_rs2_val, ex_imm;
  logic [`RV_REG_W-1:0] ex_rs1_idx, ex_rs2_idx, ex_rd;
  rv_ex_pkg::opcode_t   ex_opcode;
  rv_ex_pkg::alu_op_t   ex_alu_op;
  rv_ex_pkg::cmp_op_t   ex_cmp_op;
  rv_ex_pkg::store_w_t  ex_store_w;

  logic                 mem_valid, mem_reg_write, mem_link, mem_store, mem_br_taken;
  logic [`RV_REG_W-1:0] mem_rd;
  logic [`RV_XLEN-1:0]  mem_alu, mem_pc4, mem_sdata, mem_target;
  logic [3:0]           mem_be;

  rv_decode decode (
    .clk            (clk),
    .rst            (rst),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .pc_i           (pc_i),
    .stall_i        (stall_i),
    .rs1_idx_o      (rs1_idx),
    .rs2_idx_o      (rs2_idx),
    .rs1_val_i      (rs1_val),
    .rs2_val_i      (rs2_val),
    .ex_valid_o     (ex_valid),
    .ex_pc_o        (ex_pc),
    .ex_opcode_o    (ex_opcode),
    .ex_alu_op_o    (ex_alu_op),
    .ex_cmp_op_o    (ex_cmp_op),
    .ex_store_w_o   (ex_store_w),
    .ex_rs1_idx_o   (ex_rs1_idx),
    .ex_rs2_idx_o   (ex_rs2_idx),
    .ex_rd_o        (ex_rd),
    .ex_reg_write_o (ex_reg_write),
    .ex_rs1_val_o   (ex_rs1_val),
    .ex_rs2_val_o   (ex_rs2_val),
    .ex_imm_o       (ex_imm),
    .ex_a_sel_pc_o  (ex_a_sel_pc),
    .ex_b_sel_imm_o (ex_b_sel_imm)
  );

  rv_regfile regfile (
    .clk       (clk),
    .rst       (rst),
    .rs1_idx_i (rs1_idx),
    .rs2_idx_i (rs2_idx),
    .rs1_val_o (rs1_val),
    .rs2_val_o (rs2_val),
    .we_i      (wb_we_o),
    .rd_i      (wb_rd_o),
    .wd_i      (wb_data_o),
    .stall_i   (stall_i)
  );

  rv_execute execute (
    .clk             (clk),
    .rst             (rst),
    .stall_i         (stall_i),
    .ex_valid_i      (ex_valid),
    .ex_pc_i         (ex_pc),
    .ex_opcode_i     (ex_opcode),
    .ex_alu_op_i     (ex_alu_op),
    .ex_cmp_op_i     (ex_cmp_op),
    .ex_store_w_i    (ex_store_w),
    .ex_rs1_idx_i    (ex_rs1_idx),
    .ex_rs2_idx_i    (ex_rs2_idx),
    .ex_rd_i         (ex_rd),
    .ex_reg_write_i  (ex_reg_write),
    .ex_rs1_val_i    (ex_rs1_val),
    .ex_rs2_val_i    (ex_rs2_val),
    .ex_imm_i        (ex_imm),
    .ex_a_sel_pc_i   (ex_a_sel_pc),
    .ex_b_sel_imm_i  (ex_b_sel_imm),
    .wb_we_i         (wb_we_o),
    .wb_rd_i         (wb_rd_o),
    .wb_data_i       (wb_data_o),
    .mem_valid_o     (mem_valid),
    .mem_rd_o        (mem_rd),
    .mem_reg_write_o (mem_reg_write),
    .mem_alu_o       (mem_alu),
    .mem_link_o      (mem_link),
    .mem_pc4_o       (mem_pc4),
    .mem_store_o     (mem_store),
    .mem_be_o        (mem_be),
    .mem_sdata_o     (mem_sdata),
    .mem_br_taken_o  (mem_br_taken),
    .mem_target_o    (mem_target)
  );

  rv_result result (
    .clk             (clk),
    .rst             (rst),
    .stall_i         (stall_i),
    .mem_valid_i     (mem_valid),
    .mem_rd_i        (mem_rd),
    .mem_reg_write_i (mem_reg_write),
    .mem_alu_i       (mem_alu),
    .mem_link_i      (mem_link),
    .mem_pc4_i       (mem_pc4),
    .mem_store_i     (mem_store),
    .mem_be_i        (mem_be),
    .mem_sdata_i     (mem_sdata),
    .mem_br_taken_i  (mem_br_taken),
    .mem_target_i    (mem_target),
    .wb_valid_o      (wb_valid_o),
    .wb_we_o         (wb_we_o),
    .wb_rd_o         (wb_rd_o),
    .wb_data_o       (wb_data_o),
    .st_valid_o      (st_valid_o),
    .st_addr_o       (st_addr_o),
    .st_be_o         (st_be_o),
    .st_data_o       (st_data_o),
    .br_taken_o      (br_taken_o),
    .br_target_o     (br_target_o)
  );

endmodule

`default_nettype wire

//--- rtl/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_regfile (
  input  wire                  clk,
  input  wire                  rst,
  input  wire  [`RV_REG_W-1:0] rs1_idx_i,
  input  wire  [`RV_REG_W-1:0] rs2_idx_i,
  output logic [`RV_XLEN-1:0]  rs1_val_o,
  output logic [`RV_XLEN-1:0]  rs2_val_o,
  input  wire                  we_i,
  input  wire  [`RV_REG_W-1:0] rd_i,
  input  wire  [`RV_XLEN-1:0]  wd_i,
  input  wire                  stall_i
);

  logic [`RV_XLEN-1:0] regs [0:`RV_NREGS-1];
  logic                wr_en;

  assign wr_en = we_i & ~stall_i & (rd_i != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_i] <= wd_i;
    end
  end

  // x0 reads zero; a write in the same cycle goes straight through.
  function automatic logic [`RV_XLEN-1:0] read_port(input logic [`RV_REG_W-1:0] idx);
    if (idx == '0) return '0;
    if (wr_en && rd_i == idx) return wd_i;
    return regs[idx];
  endfunction

  always_comb begin
    rs1_val_o = read_port(rs1_idx_i);
    rs2_val_o = read_port(rs2_idx_i);
  end

endmodule

`default_nettype wire

//--- rtl/rv_result.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_result (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  stall_i,
  input  wire                  mem_valid_i,
  input  wire  [`RV_REG_W-1:0] mem_rd_i,
  input  wire                  mem_reg_write_i,
  input  wire  [`RV_XLEN-1:0]  mem_alu_i,
  input  wire                  mem_link_i,
  input  wire  [`RV_XLEN-1:0]  mem_pc4_i,
  input  wire                  mem_store_i,
  input  wire  [3:0]           mem_be_i,
  input  wire  [`RV_XLEN-1:0]  mem_sdata_i,
  input  wire                  mem_br_taken_i,
  input  wire  [`RV_XLEN-1:0]  mem_target_i,
  output logic                 wb_valid_o,
  output logic                 wb_we_o,
  output logic [`RV_REG_W-1:0] wb_rd_o,
  output logic [`RV_XLEN-1:0]  wb_data_o,
  output logic                 st_valid_o,
  output logic [`RV_XLEN-1:0]  st_addr_o,
  output logic [3:0]           st_be_o,
  output logic [`RV_XLEN-1:0]  st_data_o,
  output logic                 br_taken_o,
  output logic [`RV_XLEN-1:0]  br_target_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
      wb_we_o    <= 1'b0;
      st_valid_o <= 1'b0;
      br_taken_o <= 1'b0;
    end else if (!stall_i) begin
      wb_valid_o <= mem_valid_i;
      wb_we_o    <= mem_valid_i & mem_reg_write_i;
      st_valid_o <= mem_valid_i & mem_store_i;
      br_taken_o <= mem_valid_i & mem_br_taken_i;
    end
  end

  // Jumps write the link address.
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      wb_rd_o     <= mem_rd_i;
      wb_data_o   <= mem_link_i ? mem_pc4_i : mem_alu_i;
      st_addr_o   <= mem_alu_i;
      st_be_o     <= mem_be_i;
      st_data_o   <= mem_sdata_i;
      br_target_o <= mem_target_i;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timescale 1ns/10ps --top-module rv_ex_tb -f compile.f
output=$(./obj_dir/Vrv_ex_tb) || true
printf '%s\n' "$output"
printf '%s\n' "$output" | grep -q "Everything OK"

//--- verification/rv_ex_model.svh
`ifndef RV_EX_MODEL_SVH
`define RV_EX_MODEL_SVH

// Architectural registers, updated in program order at issue time.
logic [`RV_XLEN-1:0] arch_regs [0:`RV_NREGS-1];

// One entry per issued instruction, oldest first.
logic                exp_we_q     [$];
logic [`RV_REG_W-1:0] exp_rd_q    [$];
logic [`RV_XLEN-1:0] exp_data_q   [$];
logic                exp_st_q     [$];
logic [`RV_XLEN-1:0] exp_addr_q   [$];
logic [3:0]          exp_be_q     [$];
logic [`RV_XLEN-1:0] exp_sdata_q  [$];
logic                exp_taken_q  [$];
logic [`RV_XLEN-1:0] exp_target_q [$];

task automatic model_reset();
  for (int i = 0; i < `RV_NREGS; i++) begin
    arch_regs[i] = '0;
  end
endtask

// RV32I integer operation selected by funct3, alt picks SUB or SRA.
function automatic logic [`RV_XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                input logic [`RV_XLEN-1:0] a,
                                                input logic [`RV_XLEN-1:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'b000:  return alt ? a - b : a + b;
    3'b001:  return a << sh;
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b101:  return alt ? 32'($signed(a) >>> sh) : a >> sh;
    3'b110:  return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_ref(input logic [2:0] f3, input logic [`RV_XLEN-1:0] a,
                                    input logic [`RV_XLEN-1:0] b);
  case (f3)
    rv_ex_pkg::beq:  return a == b;
    rv_ex_pkg::bne:  return a != b;
    rv_ex_pkg::blt:  return $signed(a) < $signed(b);
    rv_ex_pkg::bge:  return $signed(a) >= $signed(b);
    rv_ex_pkg::bltu: return a < b;
    default:         return a >= b;
  endcase
endfunction

task automatic model_issue(input rv_ex_pkg::opcode_t op, input logic [2:0] f3, input logic alt,
                           input logic [`RV_REG_W-1:0] rd, input logic [`RV_REG_W-1:0] rs1,
                           input logic [`RV_REG_W-1:0] rs2, input logic [`RV_XLEN-1:0] imm,
                           input logic [`RV_XLEN-1:0] pc_val);
  logic [`RV_XLEN-1:0] a, b, res, addr, target;
  logic                we, st, taken;
  logic [3:0]          mask, be;
  a      = arch_regs[rs1];
  b      = arch_regs[rs2];
  res    = '0;
  addr   = '0;
  target = '0;
  we     = 1'b0;
  st     = 1'b0;
  taken  = 1'b0;
  be     = 4'b0;
  case (op)
    rv_ex_pkg::op_reg: begin
      res = alu_ref(f3, alt, a, b);
      we  = 1'b1;
    end
    rv_ex_pkg::op_imm: begin
      res = alu_ref(f3, alt, a, imm);
      we  = 1'b1;
    end
    rv_ex_pkg::op_lui: begin
      res = imm;
      we  = 1'b1;
    end
    rv_ex_pkg::op_auipc: begin
      res = pc_val + imm;
      we  = 1'b1;
    end
    rv_ex_pkg::op_jal, rv_ex_pkg::op_jalr: begin
      res    = pc_val + 32'd4;
      we     = 1'b1;
      taken  = 1'b1;
      target = (op == rv_ex_pkg::op_jal) ? pc_val + imm : (a + imm) & ~32'd1;
    end
    rv_ex_pkg::op_br: begin
      taken  = branch_ref(f3, a, b);
      target = pc_val + imm;
    end
    rv_ex_pkg::op_store: begin
      st   = 1'b1;
      addr = a + imm;
      case (f3)
        rv_ex_pkg::sb: mask = 4'b0001;
        rv_ex_pkg::sh: mask = 4'b0011;
        default:       mask = 4'b1111;
      endcase
      be = mask << addr[1:0];
    end
    default: we = 1'b0;
  endcase
  if (rd == '0) begin
    we = 1'b0;
  end
  if (we) begin
    arch_regs[rd] = res;
  end
  exp_we_q.push_back(we);
  exp_rd_q.push_back(rd);
  exp_data_q.push_back(res);
  exp_st_q.push_back(st);
  exp_addr_q.push_back(addr);
  exp_be_q.push_back(be);
  exp_sdata_q.push_back(b);
  exp_taken_q.push_back(taken);
  exp_target_q.push_back(target);
endtask

`endif

//--- verification/rv_ex_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_ex_defines.svh"

module rv_ex_tb;

  localparam int num_instr   = 400;
  localparam int max_cycles  = 4000;
  localparam int drain_limit = 50;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 instr_valid;
  logic [31:0]          instr;
  logic [`RV_XLEN-1:0]  pc;
  logic                 stall;
  logic                 wb_valid, wb_we, st_valid, br_taken;
  logic [`RV_REG_W-1:0] wb_rd;
  logic [`RV_XLEN-1:0]  wb_data, st_addr, st_data, br_target;
  logic [3:0]           st_be;
  logic [`RV_XLEN-1:0]  cur_pc;
  logic                 fresh = 1'b0;

  `include "rv_ex_model.svh"

  rv_ex_top uut (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .stall_i       (stall),
    .wb_valid_o    (wb_valid),
    .wb_we_o       (wb_we),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .st_valid_o    (st_valid),
    .st_addr_o     (st_addr),
    .st_be_o       (st_be),
    .st_data_o     (st_data),
    .br_taken_o    (br_taken),
    .br_target_o   (br_target)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                          $time, name, got, exp));
    end
  endtask

  task automatic compare_result();
    logic                 e_we, e_st, e_taken;
    logic [`RV_REG_W-1:0] e_rd;
    logic [`RV_XLEN-1:0]  e_data, e_addr, e_sdata, e_target;
    logic [3:0]           e_be;
    if (exp_we_q.size() == 0) begin
      abort_run("a result appeared with no instruction outstanding");
    end else begin
      e_we     = exp_we_q.pop_front();
      e_rd     = exp_rd_q.pop_front();
      e_data   = exp_data_q.pop_front();
      e_st     = exp_st_q.pop_front();
      e_addr   = exp_addr_q.pop_front();
      e_be     = exp_be_q.pop_front();
      e_sdata  = exp_sdata_q.pop_front();
      e_taken  = exp_taken_q.pop_front();
      e_target = exp_target_q.pop_front();
      check_val("wb_we_o", 32'(wb_we), 32'(e_we));
      if (e_we) begin
        check_val("wb_rd_o", 32'(wb_rd), 32'(e_rd));
        check_val("wb_data_o", wb_data, e_data);
      end
      check_val("st_valid_o", 32'(st_valid), 32'(e_st));
      if (e_st) begin
        check_val("st_addr_o", st_addr, e_addr);
        check_val("st_be_o", 32'(st_be), 32'(e_be));
        check_val("st_data_o", st_data, e_sdata);
      end
      check_val("br_taken_o", 32'(br_taken), 32'(e_taken));
      if (e_taken) begin
        check_val("br_target_o", br_target, e_target);
      end
    end
  endtask

  // Outputs are read before the edge updates them, and count once
  // when the edge that produced them was neither reset nor stall.
  always @(posedge clk) begin
    if (fresh) begin
      if (wb_valid) begin
        compare_result();
      end else begin
        check_val("wb_we_o", 32'(wb_we), 32'd0);
        check_val("st_valid_o", 32'(st_valid), 32'd0);
        check_val("br_taken_o", 32'(br_taken), 32'd0);
      end
    end
    fresh = !rst && !stall;
  end

  task automatic issue_random();
    rv_ex_pkg::opcode_t   op;
    logic [`RV_REG_W-1:0] rd, rs1, rs2;
    logic [2:0]           f3;
    logic                 alt;
    logic [31:0]          imm, word, rnd;
    int                   pick;
    rd   = 5'($urandom_range(0, 7));
    rs1  = 5'($urandom_range(0, 7));
    rs2  = 5'($urandom_range(0, 7));
    f3   = 3'($urandom_range(0, 7));
    alt  = 1'b0;
    rnd  = $urandom();
    imm  = {{20{rnd[11]}}, rnd[11:0]};
    pick = int'($urandom_range(0, 15));
    case (pick)
      0, 1, 2, 3: begin
        op   = rv_ex_pkg::op_reg;
        alt  = (f3 == 3'b000 || f3 == 3'b101) && rnd[31];
        word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op};
      end
      4, 5, 6, 7: begin
        op = rv_ex_pkg::op_imm;
        // Shift immediates carry the shift amount and mark SRAI in bit 10.
        if (f3 == 3'b001 || f3 == 3'b101) begin
          alt = (f3 == 3'b101) && rnd[31];
          imm = {21'b0, alt, 5'b0, rnd[4:0]};
        end
        word = {imm[11:0], rs1, f3, rd, op};
      end
      8, 9: begin
        op   = (pick == 8) ? rv_ex_pkg::op_lui : rv_ex_pkg::op_auipc;
        imm  = {rnd[31:12], 12'b0};
        word = {imm[31:12], rd, op};
      end
      10: begin
        op   = rv_ex_pkg::op_jal;
        imm  = {{11{rnd[20]}}, rnd[20:1], 1'b0};
        word = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
      end
      11: begin
        op   = rv_ex_pkg::op_jalr;
        f3   = 3'b000;
        word = {imm[11:0], rs1, f3, rd, op};
      end
      12, 13: begin
        op = rv_ex_pkg::op_br;
        f3 = 3'($urandom_range(0, 5));
        if (f3 > 3'd1) begin
          f3 = f3 + 3'd2;
        end
        rd   = '0;
        imm  = {{19{rnd[12]}}, rnd[12:1], 1'b0};
        word = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
      end
      default: begin
        op   = rv_ex_pkg::op_store;
        f3   = 3'($urandom_range(0, 2));
        rd   = '0;
        word = {imm[11:5], rs2, rs1, f3, imm[4:0], op};
      end
    endcase
    instr_valid = 1'b1;
    instr       = word;
    pc          = cur_pc;
    model_issue(op, f3, alt, rd, rs1, rs2, imm, cur_pc);
    cur_pc = cur_pc + 32'd4;
  endtask

  initial begin
    int issued;
    int cycles;
    int stall_left;
    int wait_cycles;
    void'($urandom(99616));
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = '0;
    stall       = 1'b0;
    issued      = 0;
    cycles      = 0;
    stall_left  = 0;
    cur_pc      = {16'h0, 14'($urandom()), 2'b00};
    model_reset();
    repeat (5) @(negedge clk);
    rst = 1'b0;
    check_val("wb_valid_o", 32'(wb_valid), 32'd0);
    check_val("wb_we_o", 32'(wb_we), 32'd0);
    check_val("st_valid_o", 32'(st_valid), 32'd0);
    check_val("br_taken_o", 32'(br_taken), 32'd0);

    while (issued < num_instr) begin
      @(negedge clk);
      cycles++;
      if (cycles > max_cycles) begin
        abort_run("stimulus did not finish within the cycle limit");
      end else begin
        instr_valid = 1'b0;
        if (stall_left > 0) begin
          stall = 1'b1;
          stall_left--;
        end else if ($urandom_range(0, 19) == 0) begin
          stall      = 1'b1;
          stall_left = int'($urandom_range(0, 3));
        end else begin
          stall = 1'b0;
          if ($urandom_range(0, 3) != 0) begin
            issue_random();
            issued++;
          end
        end
      end
    end

    @(negedge clk);
    instr_valid = 1'b0;
    stall       = 1'b0;
    wait_cycles = 0;
    while (exp_we_q.size() != 0 && wait_cycles < drain_limit) begin
      @(negedge clk);
      wait_cycles++;
    end
    if (exp_we_q.size() != 0) begin
      abort_run("results were still outstanding when the drain timed out");
    end else begin
      // A few idle cycles so that a stray extra result would show.
      repeat (4) @(negedge clk);
      $display("Everything OK");
      $finish;
    end
  end

endmodule

`default_nettype wire
